//--- include/precisionMul_defines.svh
`ifndef PRECISIONMUL_DEFINES_SVH
`define PRECISIONMUL_DEFINES_SVH

// operand widths
`define PM_DATA_W       8
`define PM_WEIGHT_W     8
`define PM_NUM_WEIGHTS  4    // four weights share one APB word

// 4-bit data nibble times an 8-bit weight
`define PM_LANE_W       12
// full 8x8 product after the lane merge
`define PM_PROD_W       16

// APB slave
`define PM_APB_AW       8
`define PM_APB_DW       32

// register offsets
`define PM_ADDR_CTRL    8'h00  // mode and start
`define PM_ADDR_DATA    8'h04
`define PM_ADDR_WEIGHT  8'h08
`define PM_ADDR_STATUS  8'h0C  // done flag
`define PM_ADDR_RESULT  8'h10

`endif

//--- hw/precisionMulPkg.sv
`default_nettype none

`include "precisionMul_defines.svh"

package precisionMulPkg;

  typedef logic [`PM_DATA_W-1:0]   data_t;      // unsigned data byte
  typedef logic [`PM_WEIGHT_W-1:0] weight_t;    // two's complement weight
  typedef logic [`PM_DATA_W/2-1:0] laneData_t;  // nibble handled by one lane
  typedef logic [`PM_LANE_W-1:0]   laneSum_t;   // signed lane result
  typedef logic [`PM_PROD_W-1:0]   product_t;   // signed 8-bit mode product
  typedef logic [`PM_APB_AW-1:0]   apbAddr_t;
  typedef logic [`PM_APB_DW-1:0]   apbData_t;

  // precision of data and weights, 0 is reserved
  typedef enum logic [1:0] {
    PREC2 = 2'd1,
    PREC4 = 2'd2,
    PREC8 = 2'd3
  } precMode_t;

endpackage

`default_nettype wire

//--- hw/apbRegs.sv
`default_nettype none

`include "precisionMul_defines.svh"

module apbRegs
  import precisionMulPkg::*;
(
  input  logic      clk,
  input  logic      arstN,
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  apbAddr_t  paddr,
  input  apbData_t  pwdata,
  output apbData_t  prdata,
  output logic      pready,
  output logic      pslverr,
  output precMode_t mode,
  output laneData_t loData,
  output laneData_t hiData,
  output weight_t   loWeightP,
  output weight_t   loWeightQ,
  output weight_t   hiWeightP,
  output weight_t   hiWeightQ,
  output logic      capture,
  input  apbData_t  resultWord,
  input  logic      done
);

  localparam int StartBit = 4;

  data_t    dataReg;
  weight_t  weights [`PM_NUM_WEIGHTS];
  apbData_t weightWord;
  logic     access;
  logic     wrAccess;
  logic     hitCtrl;
  logic     hitData;
  logic     hitWeight;
  logic     hitStatus;
  logic     hitResult;
  logic     mapped;
  logic     badMode;
  logic     ctrlWrite;

  assign access   = psel & penable;  // zero wait states, so every access phase ends here
  assign wrAccess = access & pwrite;

  assign hitCtrl   = (paddr == `PM_ADDR_CTRL);
  assign hitData   = (paddr == `PM_ADDR_DATA);
  assign hitWeight = (paddr == `PM_ADDR_WEIGHT);
  assign hitStatus = (paddr == `PM_ADDR_STATUS);
  assign hitResult = (paddr == `PM_ADDR_RESULT);
  assign mapped    = hitCtrl | hitData | hitWeight | hitStatus | hitResult;

  assign badMode   = hitCtrl & pwrite & (pwdata[1:0] == 2'b00);  // reserved encoding
  assign ctrlWrite = wrAccess & hitCtrl & ~badMode;

  assign pready  = 1'b1;
  assign pslverr = access & (~mapped | badMode);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      mode    <= PREC8;
      dataReg <= '0;
      capture <= 1'b0;
      for (int k = 0; k < `PM_NUM_WEIGHTS; k++) begin
        weights[k] <= '0;
      end
    end else begin
      capture <= ctrlWrite & pwdata[StartBit];  // high for one cycle only
      if (ctrlWrite) begin
        mode <= precMode_t'(pwdata[1:0]);
      end
      if (wrAccess && hitData) begin
        dataReg <= pwdata[`PM_DATA_W-1:0];
      end
      if (wrAccess && hitWeight) begin
        for (int k = 0; k < `PM_NUM_WEIGHTS; k++) begin
          weights[k] <= pwdata[k*`PM_WEIGHT_W +: `PM_WEIGHT_W];
        end
      end
    end
  end

  // lane operand routing
  // the low lane always works on weights 1 and 2, the high lane's P follows the mode
  assign loData    = dataReg[3:0];
  assign hiData    = dataReg[7:4];
  assign loWeightP = weights[0];
  assign loWeightQ = weights[1];
  assign hiWeightQ = weights[3];  // only used in 2-bit mode

  always_comb begin
    case (mode)
      PREC8:   hiWeightP = weights[0];  // both nibbles times weight 1
      PREC4:   hiWeightP = weights[1];
      default: hiWeightP = weights[2];
    endcase
  end

  always_comb begin
    for (int k = 0; k < `PM_NUM_WEIGHTS; k++) begin
      weightWord[k*`PM_WEIGHT_W +: `PM_WEIGHT_W] = weights[k];
    end
  end

  // start reads back as 0, done is hidden while a capture is in flight
  always_comb begin
    case (paddr)
      `PM_ADDR_CTRL:   prdata = apbData_t'(mode);
      `PM_ADDR_DATA:   prdata = apbData_t'(dataReg);
      `PM_ADDR_WEIGHT: prdata = weightWord;
      `PM_ADDR_STATUS: prdata = apbData_t'(done & ~capture);
      `PM_ADDR_RESULT: prdata = resultWord;
      default:         prdata = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- hw/precisionLane.sv
`default_nettype none

module precisionLane
  import precisionMulPkg::*;
(
  input  precMode_t mode,
  input  laneData_t laneData,
  input  weight_t   weightP,
  input  weight_t   weightQ,
  output laneSum_t  laneSum
);

  logic [3:0] pSign;
  logic [3:0] qSign;
  logic [7:0] pMag;
  logic [7:0] qMag;
  logic [3:0] rowSign [2];  // one sign per 2-bit magnitude field
  logic [7:0] rowMag  [2];
  laneSum_t   term    [2][4];
  laneSum_t   rowSum  [2];

  // Sign-magnitude split at the weight precision. Each 2-bit magnitude field
  // gets the sign of the weight element it belongs to, so the partial product
  // array below never needs to know the mode.
  function automatic void splitWeight(
    input  weight_t    w,
    input  precMode_t  m,
    output logic [3:0] sgn,
    output logic [7:0] mag
  );
    case (m)
      PREC8: begin
        sgn = {4{w[7]}};
        mag = w[7] ? -w : w;  // 128 still fits unsigned
      end
      PREC4: begin
        sgn      = {{2{w[7]}}, {2{w[3]}}};
        mag[3:0] = w[3] ? -w[3:0] : w[3:0];
        mag[7:4] = w[7] ? -w[7:4] : w[7:4];
      end
      default: begin  // four 2-bit weights
        for (int k = 0; k < 4; k++) begin
          sgn[k]        = w[2*k+1];
          mag[2*k +: 2] = w[2*k+1] ? -w[2*k +: 2] : w[2*k +: 2];
        end
      end
    endcase
  endfunction

  // left shift of partial product (row, col) in the lane sum
  function automatic int unsigned ppShift(
    input precMode_t   m,
    input int unsigned row,
    input int unsigned col
  );
    case (m)
      PREC8:   return 2 * (row + col);      // full 4x8 product
      PREC4:   return 2 * (row + col % 2);  // each nibble restarts at weight 0
      default: return 0;                    // plain dot product of fields
    endcase
  endfunction

  always_comb begin
    splitWeight(weightP, mode, pSign, pMag);
    splitWeight(weightQ, mode, qSign, qMag);
  end

  // data bits 3..2 pair with Q only in 2-bit mode
  assign rowSign[0] = pSign;
  assign rowMag[0]  = pMag;
  assign rowSign[1] = (mode == PREC2) ? qSign : pSign;
  assign rowMag[1]  = (mode == PREC2) ? qMag : pMag;

  for (genvar i = 0; i < 2; i++) begin : gRow
    for (genvar j = 0; j < 4; j++) begin : gCol
      logic [3:0] ppMag;
      laneSum_t   ppSigned;

      assign ppMag      = laneData[2*i +: 2] * rowMag[i][2*j +: 2];  // unsigned 2x2
      assign ppSigned   = rowSign[i][j] ? -laneSum_t'(ppMag) : laneSum_t'(ppMag);
      assign term[i][j] = ppSigned << ppShift(mode, i, j);  // wraps, total stays in range
    end

    assign rowSum[i] = (term[i][0] + term[i][1]) + (term[i][2] + term[i][3]);
  end

  assign laneSum = rowSum[0] + rowSum[1];

endmodule

`default_nettype wire

//--- hw/resultMerge.sv
`default_nettype none

`include "precisionMul_defines.svh"

module resultMerge
  import precisionMulPkg::*;
(
  input  logic      clk,
  input  logic      arstN,
  input  precMode_t mode,
  input  logic      capture,
  input  laneSum_t  loSum,
  input  laneSum_t  hiSum,
  output apbData_t  resultWord,
  output logic      done
);

  localparam int ProdExt = `PM_APB_DW - `PM_PROD_W;
  localparam int LaneExt = `PM_APB_DW / 2 - `PM_LANE_W;

  product_t product;
  apbData_t mergedWord;

  // high lane carries data bits 7..4 so it weighs 16x
  assign product = {{(`PM_PROD_W - `PM_LANE_W){loSum[`PM_LANE_W-1]}}, loSum}
                 + {hiSum, 4'b0000};

  always_comb begin
    if (mode == PREC8) begin
      mergedWord = {{ProdExt{product[`PM_PROD_W-1]}}, product};
    end else begin
      mergedWord = {{LaneExt{hiSum[`PM_LANE_W-1]}}, hiSum,
                    {LaneExt{loSum[`PM_LANE_W-1]}}, loSum};  // two packed halves
    end
  end

  // result only moves on capture, so later operand writes leave it alone
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      resultWord <= '0;
      done       <= 1'b0;
    end else if (capture) begin
      resultWord <= mergedWord;
      done       <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- hw/precisionMulArray.sv
`default_nettype none

module precisionMulArray
  import precisionMulPkg::*;
(
  input  logic     clk,
  input  logic     arstN,
  input  logic     psel,
  input  logic     penable,
  input  logic     pwrite,
  input  apbAddr_t paddr,
  input  apbData_t pwdata,
  output apbData_t prdata,
  output logic     pready,
  output logic     pslverr
);

  precMode_t mode;
  laneData_t loData;
  laneData_t hiData;
  weight_t   loWeightP;
  weight_t   loWeightQ;
  weight_t   hiWeightP;
  weight_t   hiWeightQ;
  logic      capture;
  laneSum_t  loSum;
  laneSum_t  hiSum;
  apbData_t  resultWord;
  logic      done;

  apbRegs regs_i (
    .clk        (clk),
    .arstN      (arstN),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .mode       (mode),
    .loData     (loData),
    .hiData     (hiData),
    .loWeightP  (loWeightP),
    .loWeightQ  (loWeightQ),
    .hiWeightP  (hiWeightP),
    .hiWeightQ  (hiWeightQ),
    .capture    (capture),
    .resultWord (resultWord),
    .done       (done)
  );

  // data bits 3..0
  precisionLane laneLo_i (
    .mode     (mode),
    .laneData (loData),
    .weightP  (loWeightP),
    .weightQ  (loWeightQ),
    .laneSum  (loSum)
  );

  // data bits 7..4
  precisionLane laneHi_i (
    .mode     (mode),
    .laneData (hiData),
    .weightP  (hiWeightP),
    .weightQ  (hiWeightQ),
    .laneSum  (hiSum)
  );

  resultMerge merge_i (
    .clk        (clk),
    .arstN      (arstN),
    .mode       (mode),
    .capture    (capture),
    .loSum      (loSum),
    .hiSum      (hiSum),
    .resultWord (resultWord),
    .done       (done)
  );

endmodule

`default_nettype wire

//--- verif/precisionMulArray_checker.sv
`default_nettype none

`include "precisionMul_defines.svh"

module precisionMulArrayChecker
  import precisionMulPkg::*;
(
  input logic     clk,
  input logic     arstN,
  input logic     psel,
  input logic     penable,
  input logic     pwrite,
  input apbAddr_t paddr,
  input apbData_t pwdata,
  input logic     pready,
  input logic     pslverr,
  input logic     capture,
  input logic     done,
  input apbData_t resultWord
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int StartBit = 4;

  int unsigned assertFails;  // summed into the testbench error count
  logic        startWrite;

  initial assertFails = 0;

  // access phase of a CTRL write with start set and a valid mode
  assign startWrite = psel & penable & pwrite & (paddr == `PM_ADDR_CTRL)
                    & pwdata[StartBit] & (pwdata[1:0] != 2'b00);

  readyHigh: assert property (@(posedge clk) disable iff (!arstN) pready)
    else begin
      assertFails++;
      $error("pready went low");
    end

  errInAccess: assert property (@(posedge clk) disable iff (!arstN)
    pslverr |-> psel && penable)
    else begin
      assertFails++;
      $error("pslverr outside an access phase");
    end

  doneAfterStart: assert property (@(posedge clk) disable iff (!arstN)
    startWrite |=> capture ##1 done)
    else begin
      assertFails++;
      $error("start write not followed by capture and then done");
    end

  resultHeld: assert property (@(posedge clk) disable iff (!arstN)
    !capture |=> $stable(resultWord))
    else begin
      assertFails++;
      $error("resultWord changed without capture");
    end

endmodule

bind precisionMulArray precisionMulArrayChecker checker_i (
  .clk        (clk),
  .arstN      (arstN),
  .psel       (psel),
  .penable    (penable),
  .pwrite     (pwrite),
  .paddr      (paddr),
  .pwdata     (pwdata),
  .pready     (pready),
  .pslverr    (pslverr),
  .capture    (capture),
  .done       (done),
  .resultWord (resultWord)
);

`default_nettype wire

//--- verif/precisionMulArrayTb.sv
`default_nettype none

`include "precisionMul_defines.svh"

module precisionMulArrayTb
  import precisionMulPkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int          ClkPeriod   = 8;
  localparam int          ApbTimeout  = 8;   // cycles waiting for pready
  localparam int          DoneTimeout = 16;  // STATUS polls after a start
  localparam logic [31:0] Seed        = 32'd73;
  localparam int          StartBit    = 4;

  logic     clk;
  logic     arstN;
  logic     psel;
  logic     penable;
  logic     pwrite;
  apbAddr_t paddr;
  apbData_t pwdata;
  apbData_t prdata;
  logic     pready;
  logic     pslverr;

  logic [31:0] rngState;
  int          errCount;
  int          checkCount;
  int          testCount;
  int          testStartErr;

  precisionMulArray dut_i (
    .clk     (clk),
    .arstN   (arstN),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  function automatic logic [15:0] lcgNext();
    rngState = rngState * 32'd1664525 + 32'd1013904223;
    return rngState[31:16];  // upper half, low bits cycle too fast
  endfunction

  // sum of the signed weight elements at the given precision
  function automatic int fieldSum(input weight_t w, input precMode_t m);
    int s;
    s = 0;
    case (m)
      PREC8:   s = int'($signed(w));
      PREC4:   s = int'($signed(w[3:0])) + int'($signed(w[7:4]));
      default: begin
        for (int k = 0; k < 4; k++) begin
          s += int'($signed(w[2*k +: 2]));
        end
      end
    endcase
    return s;
  endfunction

  function automatic int laneModel(input laneData_t x, input weight_t p, input weight_t q,
                                   input precMode_t m);
    if (m == PREC2) begin
      return int'(x[1:0]) * fieldSum(p, m) + int'(x[3:2]) * fieldSum(q, m);
    end
    return int'(x) * fieldSum(p, m);
  endfunction

  function automatic apbData_t expectedResult(input precMode_t m, input data_t d,
                                              input apbData_t w);
    int prod;
    int lo;
    int hi;
    weight_t hiP;
    if (m == PREC8) begin
      prod = int'(d) * int'($signed(w[7:0]));
      return apbData_t'(prod);
    end
    hiP = (m == PREC4) ? w[15:8] : w[23:16];  // weight 2 or weight 3
    lo  = laneModel(d[3:0], w[7:0], w[15:8], m);
    hi  = laneModel(d[7:4], hiP, w[31:24], m);
    return {hi[15:0], lo[15:0]};
  endfunction

  task automatic checkValue(input string name, input apbData_t got, input apbData_t exp);
    checkCount++;
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
      errCount++;
    end
  endtask

  // one zero-wait APB transfer, setup then access
  task automatic apbXfer(input logic wr, input apbAddr_t addr, input apbData_t wdata,
                         output apbData_t rdata, output logic err);
    int waitCnt;
    waitCnt = 0;
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    #1;
    while (!pready && waitCnt < ApbTimeout) begin
      @(negedge clk);
      #1;
      waitCnt++;
    end
    if (!pready) begin
      $display("APB transfer to address 0x%h got no pready in %0d cycles", addr, ApbTimeout);
      errCount++;
    end
    rdata = prdata;  // sampled mid access phase
    err   = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic startAndWait(input precMode_t m);
    apbData_t rd;
    logic     err;
    int       polls;
    apbXfer(1'b1, `PM_ADDR_CTRL, apbData_t'(m) | (32'd1 << StartBit), rd, err);
    checkValue("pslverr", apbData_t'(err), '0);
    polls = 0;
    rd    = '0;
    while (!rd[0] && polls < DoneTimeout) begin
      apbXfer(1'b0, `PM_ADDR_STATUS, '0, rd, err);
      polls++;
    end
    if (!rd[0]) begin
      $display("done flag never set within %0d STATUS polls in mode %0d", DoneTimeout, m);
      errCount++;
    end
  endtask

  task automatic writeOperands(input data_t d, input apbData_t w);
    apbData_t rd;
    logic     err;
    apbXfer(1'b1, `PM_ADDR_DATA, apbData_t'(d), rd, err);
    checkValue("pslverr", apbData_t'(err), '0);
    apbXfer(1'b1, `PM_ADDR_WEIGHT, w, rd, err);
    checkValue("pslverr", apbData_t'(err), '0);
  endtask

  task automatic runOp(input precMode_t m, input data_t d, input apbData_t w,
                       output apbData_t result);
    logic err;
    writeOperands(d, w);
    startAndWait(m);
    apbXfer(1'b0, `PM_ADDR_RESULT, '0, result, err);
  endtask

  task automatic randomOps(input precMode_t m, input int count);
    data_t    d;
    apbData_t w;
    apbData_t got;
    for (int n = 0; n < count; n++) begin
      d = data_t'(lcgNext());
      w = {lcgNext(), lcgNext()};
      runOp(m, d, w, got);
      checkValue("RESULT", got, expectedResult(m, d, w));
    end
  endtask

  task automatic finishTest(input string name);
    testCount++;
    $display("test %-22s %0d errors", name, errCount - testStartErr);
    testStartErr = errCount;
  endtask

  initial begin
    apbData_t  rd;
    apbData_t  held;
    apbData_t  w;
    apbData_t  w2;
    data_t     d;
    data_t     d2;
    precMode_t m;
    logic      err;

    rngState     = Seed;
    errCount     = 0;
    checkCount   = 0;
    testCount    = 0;
    testStartErr = 0;
    arstN   = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    arstN = 1'b1;

    apbXfer(1'b0, `PM_ADDR_STATUS, '0, rd, err);
    checkValue("STATUS", rd, 32'h0);
    apbXfer(1'b0, `PM_ADDR_CTRL, '0, rd, err);
    checkValue("CTRL", rd, 32'h3);  // PREC8 after reset
    apbXfer(1'b0, `PM_ADDR_RESULT, '0, rd, err);
    checkValue("RESULT", rd, 32'h0);
    finishTest("reset values");

    randomOps(PREC8, 200);
    finishTest("random 8-bit");
    randomOps(PREC4, 200);
    finishTest("random 4-bit");
    randomOps(PREC2, 200);
    finishTest("random 2-bit");

    for (int n = 0; n < 10; n++) begin
      m = precMode_t'(lcgNext() % 3 + 1);
      d = data_t'(lcgNext());
      w = {lcgNext(), lcgNext()};
      runOp(m, d, w, held);
      checkValue("RESULT", held, expectedResult(m, d, w));
      d2 = data_t'(lcgNext());
      w2 = {lcgNext(), lcgNext()};
      writeOperands(d2, w2);
      apbXfer(1'b0, `PM_ADDR_RESULT, '0, rd, err);
      checkValue("RESULT", rd, held);  // no start yet
      startAndWait(m);
      apbXfer(1'b0, `PM_ADDR_RESULT, '0, rd, err);
      checkValue("RESULT", rd, expectedResult(m, d2, w2));
    end
    finishTest("result hold");

    apbXfer(1'b1, `PM_ADDR_CTRL, apbData_t'(PREC4), rd, err);
    checkValue("pslverr", apbData_t'(err), 32'h0);
    apbXfer(1'b1, 8'h14, 32'hDEADBEEF, rd, err);
    checkValue("pslverr", apbData_t'(err), 32'h1);
    apbXfer(1'b0, 8'h40, '0, rd, err);
    checkValue("pslverr", apbData_t'(err), 32'h1);
    apbXfer(1'b1, `PM_ADDR_CTRL, 32'd1 << StartBit, rd, err);  // reserved mode with start
    checkValue("pslverr", apbData_t'(err), 32'h1);
    apbXfer(1'b0, `PM_ADDR_CTRL, '0, rd, err);
    checkValue("CTRL", rd, apbData_t'(PREC4));
    apbXfer(1'b0, `PM_ADDR_RESULT, '0, held, err);
    apbXfer(1'b1, `PM_ADDR_RESULT, 32'hFFFFFFFF, rd, err);
    checkValue("pslverr", apbData_t'(err), 32'h0);
    apbXfer(1'b0, `PM_ADDR_RESULT, '0, rd, err);
    checkValue("RESULT", rd, held);
    finishTest("error responses");

    errCount += dut_i.checker_i.assertFails;
    $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
             testCount, checkCount, errCount, dut_i.checker_i.assertFails);
    if (errCount == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- precisionMulArray.f
+incdir+include
hw/precisionMulPkg.sv
hw/apbRegs.sv
hw/precisionLane.sv
hw/resultMerge.sv
hw/precisionMulArray.sv
verif/precisionMulArray_checker.sv
verif/precisionMulArrayTb.sv
